// File: stream_cfg_pkg.sv
package stream_cfg_pkg;

   // field widths follow the default top-level parameters
   localparam int CFG_ADDR_W  = 8;
   localparam int CFG_DELAY_W = 6;
   localparam int CNT_W       = 10;

   // period and duty counts
   typedef logic [CNT_W-1:0] cnt_t;

   // one channel's address pattern
   typedef struct packed {
      logic [CFG_ADDR_W-1:0]  start;
      logic [CFG_ADDR_W-1:0]  incr;
      logic [CFG_ADDR_W-1:0]  shift;
      // zero runs a single iteration
      logic [CFG_ADDR_W-1:0]  iter;
      cnt_t                   per;
      cnt_t                   duty;
      logic [CFG_DELAY_W-1:0] delay;
      logic                   disabled;
   } chan_cfg_t;

   // address generator states
   typedef enum logic [1:0] {
      GEN_IDLE,
      GEN_DELAY,
      GEN_RUN,
      GEN_DONE
   } gen_state_e;

endpackage

// File: mem_bus_pkg.sv
package mem_bus_pkg;

   // bus widths follow the default top-level parameters
   localparam int BUS_ADDR_W = 8;
   localparam int BUS_DATA_W = 32;

   // peers sharing the read port
   localparam int N_CHAN = 2;

   // host data bus write
   typedef struct packed {
      logic                    valid;
      logic [BUS_DATA_W/8-1:0] wstrb;
      logic [BUS_ADDR_W-1:0]   addr;
      logic [BUS_DATA_W-1:0]   wdata;
   } host_wr_t;

   typedef struct packed {
      logic                  req;
      logic [BUS_ADDR_W-1:0] addr;
   } rd_req_t;

   typedef struct packed {
      logic                  rvalid;
      logic [BUS_DATA_W-1:0] rdata;
   } rd_rsp_t;

   // channel that wins a tie on the next cycle
   typedef enum logic {
      PRIO_CH0,
      PRIO_CH1
   } arb_state_e;

endpackage

// File: address_gen.sv
`timescale 1ns/100ps

module address_gen #(
   parameter int ADDR_W  = 8,
   parameter int DELAY_W = 6
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      run_i,
   input  stream_cfg_pkg::chan_cfg_t cfg_i,
   input  logic                      ready_i,
   output logic                      valid_o,
   output logic [ADDR_W-1:0]         addr_o,
   output logic                      done_o
);

   import stream_cfg_pkg::*;

   gen_state_e         state_q;
   logic [DELAY_W-1:0] delay_q;
   cnt_t               inner_q;
   cnt_t               inner_nxt;
   logic [ADDR_W-1:0]  outer_left_q;
   logic [ADDR_W-1:0]  base_q;
   logic [ADDR_W-1:0]  addr_q;
   logic [DELAY_W-1:0] cfg_delay;
   logic [ADDR_W-1:0]  cfg_start;
   logic [ADDR_W-1:0]  cfg_incr;
   logic [ADDR_W-1:0]  cfg_shift;
   logic [ADDR_W-1:0]  cfg_iter;
   logic               last_step;
   logic               last_iter;
   logic               advance;

   assign cfg_delay = DELAY_W'(cfg_i.delay);
   assign cfg_start = ADDR_W'(cfg_i.start);
   assign cfg_incr  = ADDR_W'(cfg_i.incr);
   assign cfg_shift = ADDR_W'(cfg_i.shift);
   assign cfg_iter  = ADDR_W'(cfg_i.iter);

   assign inner_nxt = inner_q + cnt_t'(1);
   // a zero period acts like a period of one
   assign last_step = (inner_nxt >= cfg_i.per);
   assign last_iter = (outer_left_q <= ADDR_W'(1));

   // only the first duty steps of a period issue a read
   assign valid_o = (state_q == GEN_RUN) && (inner_q < cfg_i.duty);
   // idle steps move on every cycle, read steps wait for ready
   assign advance = (state_q == GEN_RUN) && (!valid_o || ready_i);
   assign addr_o  = addr_q;
   assign done_o  = (state_q == GEN_DONE);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q      <= GEN_IDLE;
         delay_q      <= '0;
         inner_q      <= '0;
         outer_left_q <= '0;
      end else if (run_i) begin
         inner_q      <= '0;
         outer_left_q <= (cfg_iter == '0) ? ADDR_W'(1) : cfg_iter;
         // first request comes delay+1 cycles after run
         if (cfg_delay == '0) begin
            state_q <= GEN_RUN;
         end else begin
            state_q <= GEN_DELAY;
            delay_q <= cfg_delay - DELAY_W'(1);
         end
      end else begin
         case (state_q)
            GEN_DELAY: begin
               if (delay_q == '0) begin
                  state_q <= GEN_RUN;
               end else begin
                  delay_q <= delay_q - DELAY_W'(1);
               end
            end
            GEN_RUN: begin
               if (advance) begin
                  if (!last_step) begin
                     inner_q <= inner_nxt;
                  end else begin
                     inner_q      <= '0;
                     outer_left_q <= outer_left_q - ADDR_W'(1);
                     if (last_iter) begin
                        state_q <= GEN_DONE;
                     end
                  end
               end
            end
            default: begin
            end
         endcase
      end
   end

   // base tracks start + outer*shift, addr adds inner*incr on top
   always_ff @(posedge clk) begin
      if (run_i) begin
         base_q <= cfg_start;
         addr_q <= cfg_start;
      end else if (advance) begin
         if (last_step) begin
            base_q <= base_q + cfg_shift;
            addr_q <= base_q + cfg_shift;
         end else begin
            addr_q <= addr_q + cfg_incr;
         end
      end
   end

endmodule

// File: output_channel.sv
`timescale 1ns/100ps

module output_channel #(
   parameter int ADDR_W  = 8,
   parameter int DATA_W  = 32,
   parameter int DELAY_W = 6
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      run_i,
   input  logic                      running_i,
   input  stream_cfg_pkg::chan_cfg_t cfg_i,
   output mem_bus_pkg::rd_req_t      req_o,
   input  logic                      grant_i,
   input  mem_bus_pkg::rd_rsp_t      rsp_i,
   output logic [DATA_W-1:0]         out_o,
   output logic                      out_valid_o,
   output logic                      done_o
);

   import mem_bus_pkg::*;

   logic              gen_run;
   logic              gen_valid;
   logic              gen_done;
   logic [ADDR_W-1:0] gen_addr;
   logic              out_valid_q;
   logic [DATA_W-1:0] out_data_q;

   // a disabled channel never starts
   assign gen_run = run_i & ~cfg_i.disabled;

   address_gen #(
      .ADDR_W (ADDR_W),
      .DELAY_W(DELAY_W)
   ) u_addr_gen (
      .clk    (clk),
      .rst    (rst),
      .run_i  (gen_run),
      .cfg_i  (cfg_i),
      .ready_i(grant_i),
      .valid_o(gen_valid),
      .addr_o (gen_addr),
      .done_o (gen_done)
   );

   // request held until the arbiter grants it
   assign req_o.req  = gen_valid;
   assign req_o.addr = BUS_ADDR_W'(gen_addr);

   // response lands one cycle after the grant, output one more
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out_valid_q <= 1'b0;
         out_data_q  <= '0;
      end else begin
         out_valid_q <= rsp_i.rvalid;
         if (rsp_i.rvalid) begin
            out_data_q <= DATA_W'(rsp_i.rdata);
         end
      end
   end

   assign out_o       = running_i ? out_data_q : '0;
   assign out_valid_o = out_valid_q;
   assign done_o      = gen_done | cfg_i.disabled;

endmodule

// File: read_arbiter.sv
`timescale 1ns/100ps

module read_arbiter #(
   parameter int ADDR_W = 8,
   parameter int DATA_W = 32
) (
   input  logic                          clk,
   input  logic                          rst,
   input  mem_bus_pkg::rd_req_t          req_i [mem_bus_pkg::N_CHAN],
   output logic [mem_bus_pkg::N_CHAN-1:0] grant_o,
   output logic [ADDR_W-1:0]             mem_addr_o,
   output logic                          mem_rd_o,
   input  logic [DATA_W-1:0]             mem_rdata_i,
   output mem_bus_pkg::rd_rsp_t          rsp_o [mem_bus_pkg::N_CHAN]
);

   import mem_bus_pkg::*;

   arb_state_e prio_q;
   logic       contested;
   logic       gnt_valid_q;
   logic       gnt_idx_q;

   assign contested = req_i[0].req & req_i[1].req;

   // lone requester wins, a tie goes to the favoured channel
   assign grant_o[0] = req_i[0].req & (!req_i[1].req | (prio_q == PRIO_CH0));
   assign grant_o[1] = req_i[1].req & (!req_i[0].req | (prio_q == PRIO_CH1));

   assign mem_rd_o   = |grant_o;
   assign mem_addr_o = grant_o[1] ? ADDR_W'(req_i[1].addr) : ADDR_W'(req_i[0].addr);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         prio_q      <= PRIO_CH0;
         gnt_valid_q <= 1'b0;
         gnt_idx_q   <= 1'b0;
      end else begin
         // the loser of a tie is favoured next time
         if (contested) begin
            prio_q <= (prio_q == PRIO_CH0) ? PRIO_CH1 : PRIO_CH0;
         end
         gnt_valid_q <= mem_rd_o;
         gnt_idx_q   <= grant_o[1];
      end
   end

   // ram data is one cycle behind the grant, steer it to that channel
   always_comb begin
      for (int i = 0; i < N_CHAN; i++) begin
         rsp_o[i].rvalid = gnt_valid_q && (int'(gnt_idx_q) == i);
         rsp_o[i].rdata  = BUS_DATA_W'(mem_rdata_i);
      end
   end

endmodule

// File: stream_ram.sv
`timescale 1ns/100ps

module stream_ram #(
   parameter int ADDR_W = 8,
   parameter int DATA_W = 32
) (
   input  logic                  clk,
   input  mem_bus_pkg::host_wr_t wr_i,
   input  logic                  rd_en_i,
   input  logic [ADDR_W-1:0]     rd_addr_i,
   output logic [DATA_W-1:0]     rd_data_o
);

   localparam int DEPTH  = 2 ** ADDR_W;
   localparam int NBYTES = DATA_W / 8;

   logic [DATA_W-1:0] mem_q [DEPTH];
   logic [ADDR_W-1:0] wr_addr;
   logic [DATA_W-1:0] wr_data;
   logic [NBYTES-1:0] wr_strb;
   logic              wr_en;

   assign wr_addr = ADDR_W'(wr_i.addr);
   assign wr_data = DATA_W'(wr_i.wdata);
   assign wr_strb = NBYTES'(wr_i.wstrb);
   assign wr_en   = wr_i.valid & (|wr_strb);

   // only strobed bytes change
   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (wr_strb[b]) begin
               mem_q[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
            end
         end
      end
   end

   // same-cycle write leaves the old word on the read port
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data_o <= mem_q[rd_addr_i];
      end
   end

endmodule

// File: stream_out_top.sv
`timescale 1ns/100ps

module stream_out_top #(
   parameter int ADDR_W  = 8,
   parameter int DATA_W  = 32,
   parameter int DELAY_W = 6
) (
   input  logic                           clk,
   input  logic                           rst,
   input  mem_bus_pkg::host_wr_t          host_i,
   input  logic                           run_i,
   input  logic                           running_i,
   input  stream_cfg_pkg::chan_cfg_t      cfg_i [mem_bus_pkg::N_CHAN],
   output logic [DATA_W-1:0]              out_o [mem_bus_pkg::N_CHAN],
   output logic [mem_bus_pkg::N_CHAN-1:0] out_valid_o,
   output logic [mem_bus_pkg::N_CHAN-1:0] done_o
);

   import mem_bus_pkg::*;
   import stream_cfg_pkg::*;

   host_wr_t          host_q;
   rd_req_t           rd_req [N_CHAN];
   rd_rsp_t           rd_rsp [N_CHAN];
   logic [N_CHAN-1:0] rd_grant;
   logic [ADDR_W-1:0] mem_rd_addr;
   logic              mem_rd;
   logic [DATA_W-1:0] mem_rd_data;

   // package field widths must agree with the parameters
   if ((CFG_ADDR_W != ADDR_W) || (CFG_DELAY_W != DELAY_W)) begin : g_cfg_width_err
      $error("chan_cfg_t field widths do not match ADDR_W/DELAY_W");
   end
   if ((BUS_ADDR_W != ADDR_W) || (BUS_DATA_W != DATA_W)) begin : g_bus_width_err
      $error("host and read bus widths do not match ADDR_W/DATA_W");
   end

   // host write takes one register stage before the ram
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         host_q <= '0;
      end else begin
         host_q <= host_i;
      end
   end

   stream_ram #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) u_ram (
      .clk      (clk),
      .wr_i     (host_q),
      .rd_en_i  (mem_rd),
      .rd_addr_i(mem_rd_addr),
      .rd_data_o(mem_rd_data)
   );

   read_arbiter #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) u_arb (
      .clk        (clk),
      .rst        (rst),
      .req_i      (rd_req),
      .grant_o    (rd_grant),
      .mem_addr_o (mem_rd_addr),
      .mem_rd_o   (mem_rd),
      .mem_rdata_i(mem_rd_data),
      .rsp_o      (rd_rsp)
   );

   for (genvar g = 0; g < N_CHAN; g++) begin : g_chan
      output_channel #(
         .ADDR_W (ADDR_W),
         .DATA_W (DATA_W),
         .DELAY_W(DELAY_W)
      ) u_chan (
         .clk        (clk),
         .rst        (rst),
         .run_i      (run_i),
         .running_i  (running_i),
         .cfg_i      (cfg_i[g]),
         .req_o      (rd_req[g]),
         .grant_i    (rd_grant[g]),
         .rsp_i      (rd_rsp[g]),
         .out_o      (out_o[g]),
         .out_valid_o(out_valid_o[g]),
         .done_o     (done_o[g])
      );
   end

endmodule

// File: tb_stream_out.sv
`timescale 1ns/100ps

module tb_stream_out;

   import stream_cfg_pkg::*;
   import mem_bus_pkg::*;

   localparam int ADDR_W  = 8;
   localparam int DATA_W  = 32;
   localparam int DELAY_W = 6;
   localparam int TIMEOUT = 2000;

   // one table row, both channels plus expected word counts
   typedef struct packed {
      chan_cfg_t [N_CHAN-1:0] cfg;
      logic                   running;
      cnt_t [N_CHAN-1:0]      cnt;
   } row_t;

   logic              clk = 1'b0;
   logic              rst;
   host_wr_t          host_i;
   logic              run_i;
   logic              running_i;
   chan_cfg_t         cfg_i [N_CHAN];
   logic [DATA_W-1:0] out_o [N_CHAN];
   logic [N_CHAN-1:0] out_valid_o;
   logic [N_CHAN-1:0] done_o;

   logic [DATA_W-1:0] mirror [2**ADDR_W];
   logic [DATA_W-1:0] got_q [N_CHAN][$];
   logic [DATA_W-1:0] exp_q [N_CHAN][$];
   row_t              rows [$];
   int                data_errs = 0;
   int                count_errs = 0;
   int                flag_errs = 0;
   int                timeouts = 0;

   stream_out_top #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W),
      .DELAY_W(DELAY_W)
   ) dut (
      .clk        (clk),
      .rst        (rst),
      .host_i     (host_i),
      .run_i      (run_i),
      .running_i  (running_i),
      .cfg_i      (cfg_i),
      .out_o      (out_o),
      .out_valid_o(out_valid_o),
      .done_o     (done_o)
   );

   always #50 clk = ~clk;

   task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
         data_errs++;
      end
   endtask

   task automatic check_count(input string name, input cnt_t got, input cnt_t exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
         count_errs++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
         flag_errs++;
      end
   endtask

   function automatic chan_cfg_t make_cfg(input int start, input int incr, input int shift,
                                          input int iter, input int per, input int duty,
                                          input int delay, input bit dis);
      chan_cfg_t c;
      c.start    = CFG_ADDR_W'(start);
      c.incr     = CFG_ADDR_W'(incr);
      c.shift    = CFG_ADDR_W'(shift);
      c.iter     = CFG_ADDR_W'(iter);
      c.per      = cnt_t'(per);
      c.duty     = cnt_t'(duty);
      c.delay    = CFG_DELAY_W'(delay);
      c.disabled = dis;
      return c;
   endfunction

   task automatic add_row(input chan_cfg_t c0, input chan_cfg_t c1, input logic running,
                          input int n0, input int n1);
      row_t r;
      r.cfg[0]  = c0;
      r.cfg[1]  = c1;
      r.running = running;
      r.cnt[0]  = cnt_t'(n0);
      r.cnt[1]  = cnt_t'(n1);
      rows.push_back(r);
   endtask

   // mirror follows the byte strobe rule
   task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [DATA_W/8-1:0] strb);
      @(posedge clk);
      #10;
      host_i = '{valid: 1'b1, wstrb: strb, addr: addr, wdata: data};
      for (int b = 0; b < DATA_W / 8; b++) begin
         if (strb[b]) begin
            mirror[addr][b*8 +: 8] = data[b*8 +: 8];
         end
      end
   endtask

   // walk iterations and period steps, reads only below duty
   task automatic build_expected(input int ch, input chan_cfg_t c, input logic running);
      int iters;
      logic [ADDR_W-1:0] a;
      exp_q[ch].delete();
      iters = (c.iter == 0) ? 1 : int'(c.iter);
      if (!c.disabled) begin
         for (int o = 0; o < iters; o++) begin
            for (int i = 0; i < int'(c.per); i++) begin
               if (i < int'(c.duty)) begin
                  a = ADDR_W'(int'(c.start) + o * int'(c.shift) + i * int'(c.incr));
                  exp_q[ch].push_back(running ? mirror[a] : '0);
               end
            end
         end
      end
   endtask

   // gathers strobed words until both channels are done plus a short tail
   task automatic collect_row(input int r, output bit ok);
      int tail;
      logic [N_CHAN-1:0] seen;
      ok = 1'b0;
      tail = 0;
      seen = '0;
      for (int cyc = 0; cyc < TIMEOUT; cyc++) begin
         @(negedge clk);
         for (int ch = 0; ch < N_CHAN; ch++) begin
            if (out_valid_o[ch]) begin
               got_q[ch].push_back(out_o[ch]);
            end
            // done drops on run and holds once raised
            if (cyc == 0 || seen[ch] || rows[r].cfg[ch].disabled) begin
               check_flag($sformatf("done_o[%0d]", ch), done_o[ch],
                          seen[ch] | rows[r].cfg[ch].disabled);
            end
            seen[ch] = seen[ch] | done_o[ch];
         end
         if (&seen) begin
            tail++;
         end
         if (tail > 3) begin
            ok = 1'b1;
            break;
         end
      end
      if (!ok) begin
         $display("timeout: row %0d did not finish within %0d cycles", r, TIMEOUT);
         timeouts++;
      end
   endtask

   initial begin
      bit ok;
      int total;
      void'($urandom(32'h68e3_d98d));
      rst       = 1'b1;
      host_i    = '0;
      run_i     = 1'b0;
      running_i = 1'b0;
      cfg_i[0]  = '0;
      cfg_i[1]  = '0;
      repeat (5) @(posedge clk);
      #10;
      rst = 1'b0;

      @(negedge clk);
      for (int ch = 0; ch < N_CHAN; ch++) begin
         check_flag($sformatf("out_valid_o[%0d]", ch), out_valid_o[ch], 1'b0);
         check_flag($sformatf("done_o[%0d]", ch), done_o[ch], 1'b0);
         check_data($sformatf("out_o[%0d]", ch), out_o[ch], '0);
      end

      // full words first, then partial strobes on top
      for (int a = 0; a < 2**ADDR_W; a++) begin
         host_write(ADDR_W'(a), DATA_W'($urandom), '1);
      end
      for (int k = 0; k < 64; k++) begin
         host_write(ADDR_W'($urandom), DATA_W'($urandom), (DATA_W/8)'($urandom));
      end
      @(posedge clk);
      #10;
      host_i.valid = 1'b0;

      add_row(make_cfg(0, 1, 0, 0, 4, 4, 0, 0), make_cfg(0, 0, 0, 0, 1, 1, 0, 1), 1, 4, 0);
      add_row(make_cfg(10, 2, 16, 3, 5, 3, 2, 0), make_cfg(12, 1, 8, 2, 4, 4, 0, 0), 1, 9, 8);
      add_row(make_cfg(250, 3, 7, 2, 3, 3, 0, 0), make_cfg(5, 255, 0, 1, 6, 2, 5, 0), 1, 6, 2);
      add_row(make_cfg(0, 0, 0, 0, 1, 1, 0, 1), make_cfg(100, 1, 4, 4, 2, 2, 1, 0), 1, 0, 8);
      add_row(make_cfg(0, 5, 1, 2, 3, 3, 0, 0), make_cfg(0, 5, 1, 2, 3, 1, 0, 0), 0, 6, 2);
      add_row(make_cfg(40, 1, 10, 2, 2, 5, 3, 0), make_cfg(200, 4, 60, 3, 4, 2, 63, 0), 1, 4, 6);
      add_row(make_cfg(30, 1, 0, 0, 8, 8, 0, 0), make_cfg(30, 1, 0, 0, 8, 8, 0, 0), 1, 8, 8);
      add_row(make_cfg(0, 1, 0, 2, 5, 0, 0, 0), make_cfg(128, 16, 1, 5, 16, 16, 0, 0), 1, 0, 80);

      foreach (rows[r]) begin
         @(posedge clk);
         #10;
         cfg_i[0]  = rows[r].cfg[0];
         cfg_i[1]  = rows[r].cfg[1];
         running_i = rows[r].running;
         for (int ch = 0; ch < N_CHAN; ch++) begin
            build_expected(ch, rows[r].cfg[ch], rows[r].running);
            got_q[ch].delete();
         end
         @(posedge clk);
         #10;
         run_i = 1'b1;
         @(posedge clk);
         #10;
         run_i = 1'b0;
         collect_row(r, ok);
         if (!ok) begin
            break;
         end
         for (int ch = 0; ch < N_CHAN; ch++) begin
            check_count($sformatf("row %0d ch%0d word count", r, ch),
                        cnt_t'(got_q[ch].size()), rows[r].cnt[ch]);
            for (int k = 0; k < got_q[ch].size() && k < exp_q[ch].size(); k++) begin
               check_data($sformatf("row %0d out_o[%0d] word %0d", r, ch, k),
                          got_q[ch][k], exp_q[ch][k]);
            end
         end
      end

      total = data_errs + count_errs + flag_errs + timeouts;
      $display("errors: data %0d, count %0d, flag %0d, timeout %0d",
               data_errs, count_errs, flag_errs, timeouts);
      if (total == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// File: sources.f
stream_cfg_pkg.sv
mem_bus_pkg.sv
address_gen.sv
output_channel.sv
read_arbiter.sv
stream_ram.sv
stream_out_top.sv
tb_stream_out.sv
